// File: rtl/pager_pkg.sv
// shared widths, port addresses, reset pages and the xxF7 data layout; imported by every pager block
package pager_pkg;

	// page and address geometry
	localparam int page_w       = 8;                  // one page selects 16 KB of a 4 MB space
	localparam int win_offset_w = 14;                 // offset inside a 16 KB window
	localparam int phys_addr_w  = page_w + win_offset_w; // 22-bit physical address

	// fixed pages
	localparam logic [page_w-1:0] nmi_page  = 8'hFF; // last RAM page, window 0 during NMI
	localparam logic [page_w-1:0] off_page  = 8'hFF; // service ROM page, pager off
	localparam logic [page_w-1:0] ram0_page = 8'h00; // RAM0 forced into window 0
	localparam logic [page_w-1:0] rst_page  = 8'h00; // stored and output page after reset

	// DOS entry and Z80 clock stall
	localparam logic [7:0] dos_fetch_hi = 8'h3D;      // opcode fetch at 3Dxx turns DOS on
	localparam int         stall_cycles = 4;          // fclk cycles of zclk_stall
	localparam int         stall_cnt_w  = $clog2(stall_cycles);

	// I/O port addresses
	localparam logic [7:0]  port_f7_lo = 8'hF7;       // xxF7 ATM ports, window in a15..a14
	localparam logic [15:0] port_7ffd  = 16'h7FFD;    // pent1m memory port

	// data byte of an xxF7 write
	// a11=1 selects the 1 MB view, a11=0 the 4 MB RAM view
	typedef union packed
	{
		struct packed
		{
			logic       dos_7ffd;  // let 7FFD bits (ram) or dos (rom) replace low page bits
			logic       ram_n_rom; // 1 = window holds RAM
			logic [5:0] page;      // page inside the 1 MB area
		} mb1;
		logic [page_w-1:0] mb4;    // full RAM page, always RAM
	} atm_port_data_t;

	// pages are kept complemented, as the ATM hardware writes them

endpackage : pager_pkg

// File: rtl/zbus_if.sv
// Z80 bus bundle with fclk-phase strobes; io side for port logic, fetch side for DOS tracking
`timescale 1ns/1ns

interface zbus_if;

	logic [15:0] za;     // address bus
	logic [7:0]  zd;     // data bus, only written data used here
	logic        mreq_n; // memory request
	logic        iorq_n; // I/O request
	logic        rd_n;   // read strobe
	logic        wr_n;   // write strobe
	logic        m1_n;   // opcode fetch cycle
	logic        zpos;   // fclk cycle before Z80 clock rising edge
	logic        zneg;   // fclk cycle before Z80 clock falling edge

	// port write decode and page register loading
	modport io
	(
		input za, zd, iorq_n, wr_n, zpos
	);

	// opcode fetch tracking for DOS on/off
	modport fetch
	(
		input za, mreq_n, rd_n, m1_n, zpos, zneg
	);

endinterface : zbus_if

// File: rtl/port_decoder.sv
// Z80 I/O write decoder; holds the pent1m 7FFD bits and issues the one-cycle xxF7 write strobe
`timescale 1ns/1ns

module port_decoder
(
	input  logic                     fclk,
	input  logic                     arst_n,
	zbus_if.io                       bus,
	output logic                     f7_wr,     // one fclk pulse per xxF7 write
	output logic [1:0]               f7_window, // target window, a15..a14 of the port
	output pager_pkg::atm_port_data_t f7_data,  // latched data byte
	output logic                     rom_sel,   // 7FFD d4, picks page bank
	output logic [5:0]               pent_page  // 7FFD pent1m page bits
);
	import pager_pkg::*;

	logic iow;      // I/O write active now
	logic iow_prev; // same, at previous zpos
	logic iow_stb;  // first zpos of a write cycle
	logic hit_f7;
	logic hit_7ffd;

	assign iow = !bus.iorq_n && !bus.wr_n;

	// one strobe per cycle, even though iorq/wr stay low for several zpos
	assign iow_stb = bus.zpos && iow && !iow_prev;

	assign hit_f7   = (bus.za[7:0] == port_f7_lo); // xxF7, any high byte
	assign hit_7ffd = (bus.za == port_7ffd);       // full 16-bit compare

	always_ff @(posedge fclk or negedge arst_n)
		if (!arst_n)
			iow_prev <= 1'b0;
		else if (bus.zpos)
			iow_prev <= iow;

	// strobe is registered, so it is high for exactly the fclk after the zpos edge
	always_ff @(posedge fclk or negedge arst_n)
		if (!arst_n)
			f7_wr <= 1'b0;
		else
			f7_wr <= iow_stb && hit_f7;

	// window and data ride with the strobe
	always_ff @(posedge fclk)
		if (iow_stb && hit_f7)
		begin
			f7_window <= bus.za[15:14];
			f7_data   <= bus.zd; // decoded later by view, see window_pager
		end

	// 7FFD register
	always_ff @(posedge fclk or negedge arst_n)
		if (!arst_n)
		begin
			rom_sel   <= 1'b0;
			pent_page <= 6'd0;
		end
		else if (iow_stb && hit_7ffd)
		begin
			rom_sel   <= bus.zd[4];
			// pentagon 1024 page order: d5, d7, d6, d2..d0
			pent_page <= {bus.zd[5], bus.zd[7:6], bus.zd[2:0]};
		end

endmodule : port_decoder

// File: rtl/window_pager.sv
// page registers for the four 16 KB windows; produces the registered page and rom flag per window
`timescale 1ns/1ns

module window_pager
(
	input  logic                                 fclk,
	input  logic                                 arst_n,
	zbus_if.io                                   bus,       // a11 picks the xxF7 data view
	input  logic                                 f7_wr,
	input  logic [1:0]                           f7_window,
	input  pager_pkg::atm_port_data_t            f7_data,
	input  logic                                 rom_sel,   // bank of page registers in use
	input  logic [5:0]                           pent_page,
	input  logic                                 dos,
	input  logic                                 pager_off, // service ROM everywhere
	input  logic                                 in_nmi,
	input  logic                                 ram0_0,    // pent1m RAM0 in window 0
	output logic [3:0][pager_pkg::page_w-1:0]    win_page,
	output logic [3:0]                           win_romnram // 1 = ROM
);
	import pager_pkg::*;

	// two banks per window, bank chosen by rom_sel
	logic [3:0][1:0][page_w-1:0] pages;    // stored complemented
	logic [3:0][1:0]             ramnrom;  // 1 = RAM
	logic [3:0][1:0]             dos_7ffd; // 7FFD/dos substitution enable

	// active bank of each window
	logic [3:0][page_w-1:0] cur_page;
	logic [3:0]             cur_ram;
	logic [3:0]             cur_dos7;

	// xxF7 writes, only the bank selected right now is touched
	always_ff @(posedge fclk or negedge arst_n)
		if (!arst_n)
		begin
			pages    <= {8{rst_page}};
			ramnrom  <= '0; // all windows ROM
			dos_7ffd <= '0;
		end
		else if (f7_wr)
		begin
			if (bus.za[11])
			begin // 1 MB format, keeps top two bits at 00 after complement
				pages[f7_window][rom_sel]    <= ~{2'b11, f7_data.mb1.page};
				ramnrom[f7_window][rom_sel]  <= f7_data.mb1.ram_n_rom;
				dos_7ffd[f7_window][rom_sel] <= f7_data.mb1.dos_7ffd;
			end
			else
			begin // 4 MB format, always RAM
				pages[f7_window][rom_sel]   <= ~f7_data.mb4;
				ramnrom[f7_window][rom_sel] <= 1'b1;
				// dos_7ffd left alone so 7FFD mapping works over all 4 MB
			end
		end

	always_comb
		for (int w = 0; w < 4; w++)
		begin
			cur_page[w] = pages[w][rom_sel];
			cur_ram[w]  = ramnrom[w][rom_sel];
			cur_dos7[w] = dos_7ffd[w][rom_sel];
		end

	// resolved page per window, priority top to bottom
	always_ff @(posedge fclk or negedge arst_n)
		if (!arst_n)
		begin
			win_page    <= {4{rst_page}};
			win_romnram <= '1;
		end
		else
		begin
			for (int w = 0; w < 4; w++)
			begin
				if (pager_off)
				begin
					win_romnram[w] <= 1'b1;
					win_page[w]    <= off_page;
				end
				else if (w == 0 && in_nmi) // nmi beats ram0
				begin
					win_romnram[w] <= 1'b0;
					win_page[w]    <= nmi_page;
				end
				else if (w == 0 && ram0_0)
				begin
					win_romnram[w] <= 1'b0;
					win_page[w]    <= ram0_page;
				end
				else
				begin
					win_romnram[w] <= ~cur_ram[w];
					if (cur_dos7[w] && cur_ram[w])
						win_page[w] <= {cur_page[w][7:6], pent_page}; // 1 MB from 7FFD
					else if (cur_dos7[w])
						win_page[w] <= {cur_page[w][7:1], dos};       // basic/dos rom pair
					else
						win_page[w] <= cur_page[w];
				end
			end
		end

endmodule : window_pager

// File: rtl/dos_tracker.sv
// DOS state from Z80 opcode fetches; stalls the Z80 clock while the DOS ROM comes in
`timescale 1ns/1ns

module dos_tracker
(
	input  logic  fclk,
	input  logic  arst_n,
	zbus_if.fetch bus,
	input  logic  rom_sel,   // 7FFD d4, dos entry only from basic48 rom
	output logic  dos,
	output logic  zclk_stall
);
	import pager_pkg::*;

	logic                   m1_n_reg;   // m1_n at last zpos
	logic                   mreq_n_reg; // mreq_n at last zneg
	logic                   fetch_stb;  // falling mreq of an opcode fetch
	logic                   dos_on;
	logic                   dos_off;
	logic [stall_cnt_w-1:0] stall_cnt;  // cycles of stall left after the strobe

	always_ff @(posedge fclk or negedge arst_n)
		if (!arst_n)
			m1_n_reg <= 1'b1;
		else if (bus.zpos)
			m1_n_reg <= bus.m1_n;

	always_ff @(posedge fclk or negedge arst_n)
		if (!arst_n)
			mreq_n_reg <= 1'b1;
		else if (bus.zneg)
			mreq_n_reg <= bus.mreq_n;

	// refresh has m1 high and rd high, so only the real fetch passes
	assign fetch_stb = bus.zneg && !m1_n_reg && !bus.rd_n && !bus.mreq_n && mreq_n_reg;

	assign dos_on  = fetch_stb && (bus.za[15:8] == dos_fetch_hi) && rom_sel;
	assign dos_off = fetch_stb && (bus.za[15:14] != 2'b00); // any fetch from 4000h up

	always_ff @(posedge fclk or negedge arst_n)
		if (!arst_n)
			dos <= 1'b0;
		else if (dos_on)
			dos <= 1'b1;
		else if (dos_off)
			dos <= 1'b0;

	// strobe cycle plus stall_cycles-1 counted ones
	always_ff @(posedge fclk or negedge arst_n)
		if (!arst_n)
			stall_cnt <= '0;
		else if (dos_on)
			stall_cnt <= stall_cnt_w'(stall_cycles - 1);
		else if (stall_cnt != '0)
			stall_cnt <= stall_cnt - 1'b1;

	assign zclk_stall = dos_on || (stall_cnt != '0); // rom needs time for the new data

endmodule : dos_tracker

// File: rtl/mem_addr_mux.sv
// picks the page of the window addressed now and builds the 22-bit memory address and rom select
`timescale 1ns/1ns

module mem_addr_mux
(
	input  logic [3:0][pager_pkg::page_w-1:0]   win_page,
	input  logic [3:0]                          win_romnram,
	input  logic [1:0]                          za_hi,   // window number
	input  logic [pager_pkg::win_offset_w-1:0]  za_lo,   // offset in window
	output logic [pager_pkg::phys_addr_w-1:0]   mem_addr,
	output logic                                mem_romnram // 1 = ROM chip
);
	import pager_pkg::*;

	logic [page_w-1:0] cur_page; // page of addressed window

	// purely combinational, follows za within the cycle
	always_comb
	begin
		cur_page    = win_page[za_hi];
		mem_romnram = win_romnram[za_hi];
	end

	// page on top, offset below
	assign mem_addr = {cur_page, za_lo};

endmodule : mem_addr_mux

// File: rtl/mem_pager_top.sv
// pager top level with plain Z80 bus ports; wires decoder, window pager, DOS tracker and address mux
`timescale 1ns/1ns

module mem_pager_top
(
	input  logic                              fclk,
	input  logic                              arst_n,
	input  logic                              zpos,
	input  logic                              zneg,
	input  logic [15:0]                       za,
	input  logic [7:0]                        zd,
	input  logic                              mreq_n,
	input  logic                              iorq_n,
	input  logic                              rd_n,
	input  logic                              wr_n,
	input  logic                              m1_n,
	input  logic                              pager_off,
	input  logic                              in_nmi,
	input  logic                              ram0_0,
	output logic [pager_pkg::phys_addr_w-1:0] mem_addr,
	output logic                              mem_romnram,
	output logic                              dos,
	output logic                              zclk_stall
);
	import pager_pkg::*;

	zbus_if bus();

	logic                   f7_wr;
	logic [1:0]             f7_window;
	atm_port_data_t         f7_data;
	logic                   rom_sel;
	logic [5:0]             pent_page;
	logic [3:0][page_w-1:0] win_page;
	logic [3:0]             win_romnram;

	// bus bundle from the top ports
	assign bus.za     = za;
	assign bus.zd     = zd;
	assign bus.mreq_n = mreq_n;
	assign bus.iorq_n = iorq_n;
	assign bus.rd_n   = rd_n;
	assign bus.wr_n   = wr_n;
	assign bus.m1_n   = m1_n;
	assign bus.zpos   = zpos;
	assign bus.zneg   = zneg;

	port_decoder u_port_decoder
	(
		.fclk(fclk), .arst_n(arst_n), .bus(bus),
		.f7_wr(f7_wr), .f7_window(f7_window), .f7_data(f7_data),
		.rom_sel(rom_sel), .pent_page(pent_page)
	);

	window_pager u_window_pager
	(
		.fclk(fclk), .arst_n(arst_n), .bus(bus),
		.f7_wr(f7_wr), .f7_window(f7_window), .f7_data(f7_data),
		.rom_sel(rom_sel), .pent_page(pent_page), .dos(dos),
		.pager_off(pager_off), .in_nmi(in_nmi), .ram0_0(ram0_0),
		.win_page(win_page), .win_romnram(win_romnram)
	);

	dos_tracker u_dos_tracker
	(
		.fclk(fclk), .arst_n(arst_n), .bus(bus), .rom_sel(rom_sel),
		.dos(dos), .zclk_stall(zclk_stall)
	);

	mem_addr_mux u_mem_addr_mux
	(
		.win_page(win_page), .win_romnram(win_romnram),
		.za_hi(za[15:14]), .za_lo(za[win_offset_w-1:0]),
		.mem_addr(mem_addr), .mem_romnram(mem_romnram)
	);

endmodule : mem_pager_top

// File: verif/mem_pager_checker.sv
// concurrent checks on DOS tracking (stall length, dos edges, quiet reset); bound into mem_pager_top
`timescale 1ns/1ns

module mem_pager_checker
(
	input logic       fclk,
	input logic       arst_n,
	input logic       zneg,
	input logic       mreq_n,
	input logic       m1_n,
	input logic [7:0] za_hi,   // a15..a8 of the Z80 bus
	input logic       rom_sel, // 7FFD d4, basic48 rom selected
	input logic       dos,
	input logic       zclk_stall
);

	// one stall is four fclk long and then drops
	stall_len: assert property (@(posedge fclk) disable iff (!arst_n)
		$rose(zclk_stall) |-> zclk_stall ##1 zclk_stall ##1 zclk_stall ##1 zclk_stall ##1 !zclk_stall)
		else $error("zclk_stall did not last exactly four fclk cycles");

	// dos comes on only one fclk after an M1 fetch at 3Dxx seen at zneg
	dos_rise: assert property (@(posedge fclk) disable iff (!arst_n)
		$rose(dos) |-> $past(zneg && !m1_n && !mreq_n && za_hi == 8'h3D && rom_sel))
		else $error("dos rose without a DOS entry fetch one cycle before");

	// dos goes off only one fclk after an M1 fetch from 4000h up
	dos_fall: assert property (@(posedge fclk) disable iff (!arst_n)
		$fell(dos) |-> $past(zneg && !m1_n && !mreq_n && za_hi[7:6] != 2'b00))
		else $error("dos fell without a high RAM fetch one cycle before");

	// nothing moves while reset is held
	rst_quiet: assert property (@(posedge fclk) !arst_n |-> !dos && !zclk_stall)
		else $error("dos or stall active during reset");

endmodule : mem_pager_checker

bind mem_pager_top mem_pager_checker u_checker
(
	.fclk(fclk),
	.arst_n(arst_n),
	.zneg(zneg),
	.mreq_n(mreq_n),
	.m1_n(m1_n),
	.za_hi(za[15:8]),
	.rom_sel(rom_sel),
	.dos(dos),
	.zclk_stall(zclk_stall)
);

// File: verif/tb_mem_pager.sv
// testbench for mem_pager_top; random Z80 port writes and fetches checked against a page model
`timescale 1ns/1ns

module tb_mem_pager;

	localparam int clk_period      = 40;
	localparam int rst_cycles      = 16;
	localparam int n_tests         = 5;
	localparam int cycles_per_test = 1000; // above the longest test
	localparam int watchdog_ns     = n_tests * cycles_per_test * 2 * clk_period;

	logic        fclk, arst_n, zpos, zneg;
	logic [15:0] za;
	logic [7:0]  zd;
	logic        mreq_n, iorq_n, rd_n, wr_n, m1_n;
	logic        pager_off, in_nmi, ram0_0;
	logic [21:0] mem_addr;
	logic        mem_romnram, dos, zclk_stall;

	// reference model, per window and per rom_sel bank
	logic [7:0] m_page [4][2]; // kept complemented like the hardware
	logic       m_ram  [4][2];
	logic       m_dos7 [4][2];
	logic       m_rom_sel, m_dos;
	logic [5:0] m_pent;

	integer seed = 32'heec5;
	int     checks, errors, test_checks, test_errors;
	string  cur_test;

	mem_pager_top DUT (.*);

	initial
	begin
		fclk = 1'b0;
		forever #(clk_period/2) fclk = ~fclk;
	end

	always @(negedge fclk)
	begin
		zpos = ~zpos; // one phase strobe per fclk, alternating
		zneg = ~zneg;
	end

	initial
	begin
		#(watchdog_ns);
		$display("watchdog expired, the tests did not finish in time");
		$display("STATUS: FAIL");
		$finish;
	end

	function automatic logic [31:0] rand32();
		return $random(seed);
	endfunction

	// page the model expects in window w, priority from top
	function automatic logic [7:0] page_of(input int w);
		logic [7:0] p;
		p = m_page[w][m_rom_sel];
		if (pager_off)
			return 8'hFF;           // service rom
		if (w == 0 && in_nmi)
			return 8'hFF;
		if (w == 0 && ram0_0)
			return 8'h00;
		if (m_dos7[w][m_rom_sel] && m_ram[w][m_rom_sel])
			p[5:0] = m_pent;        // 1 MB area from 7FFD
		else if (m_dos7[w][m_rom_sel])
			p[0] = m_dos;           // basic48 / dos rom pair
		return p;
	endfunction

	function automatic logic rom_flag(input int w);
		if (pager_off)
			return 1'b1;
		if (w == 0 && (in_nmi || ram0_0))
			return 1'b0;
		return !m_ram[w][m_rom_sel];
	endfunction

	task automatic open_test(input string name);
		cur_test    = name;
		test_checks = 0;
		test_errors = 0;
	endtask

	task automatic close_test();
		$display("test %s done: %0d checks, %0d errors", cur_test, test_checks, test_errors);
	endtask

	task automatic check_value(input string what, input logic [31:0] exp, input logic [31:0] got);
		checks++;
		test_checks++;
		assert (got === exp)
		else
		begin
			$display("ERROR %s %s: expected %0h, actual %0h", cur_test, what, exp, got);
			errors++;
			test_errors++;
		end
	endtask

	// I/O write cycle, then model update once the outputs have settled
	task automatic io_write(input logic [15:0] addr, input logic [7:0] data);
		int w;
		w = int'(addr[15:14]);
		@(negedge fclk);
		za     = addr;
		zd     = data;
		iorq_n = 1'b0;
		wr_n   = 1'b0;
		repeat (3) @(negedge fclk); // covers at least one zpos
		iorq_n = 1'b1;
		wr_n   = 1'b1;
		repeat (4) @(negedge fclk); // strobe, register and output stages
		if (addr[7:0] == 8'hF7 && addr[11])
		begin
			m_page[w][m_rom_sel] = {2'b00, ~data[5:0]};
			m_ram[w][m_rom_sel]  = data[6];
			m_dos7[w][m_rom_sel] = data[7];
		end
		else if (addr[7:0] == 8'hF7)
		begin
			m_page[w][m_rom_sel] = ~data; // 4 MB view, always ram
			m_ram[w][m_rom_sel]  = 1'b1;
		end
		else if (addr == 16'h7FFD)
		begin
			m_rom_sel = data[4];
			m_pent    = {data[5], data[7:6], data[2:0]};
		end
	endtask

	// plain memory read at a random offset of window w
	task automatic read_check(input int w);
		logic [31:0] r;
		logic [21:0] exp_addr;
		r = rand32();
		@(negedge fclk);
		za       = {w[1:0], r[13:0]};
		mreq_n   = 1'b0;
		rd_n     = 1'b0;
		exp_addr = {page_of(w), r[13:0]};
		#(clk_period/4);
		check_value("mem_addr", 32'(exp_addr), 32'(mem_addr));
		check_value("mem_romnram", 32'(rom_flag(w)), 32'(mem_romnram));
		@(negedge fclk);
		mreq_n = 1'b1;
		rd_n   = 1'b1;
	endtask

	// opcode fetch, measures the stall and checks dos afterwards
	task automatic opcode_fetch(input logic [15:0] addr);
		logic exp_on;
		int   waited;
		int   high;
		exp_on = (addr[15:8] == 8'h3D) && m_rom_sel;
		waited = 0;
		high   = 0;
		@(negedge fclk);
		za   = addr;
		m1_n = 1'b0;
		repeat (2) @(negedge fclk); // m1 must be seen at a zpos first
		mreq_n = 1'b0;
		rd_n   = 1'b0;
		#(clk_period/4);
		while (!zclk_stall && waited < 8)
		begin
			@(negedge fclk);
			#(clk_period/4);
			waited++;
		end
		while (zclk_stall && high < 16)
		begin
			high++;
			@(negedge fclk);
			#(clk_period/4);
		end
		check_value("stall cycles", exp_on ? 32'd4 : 32'd0, 32'(high));
		if (exp_on)
			m_dos = 1'b1;
		else if (addr[15:14] != 2'b00)
			m_dos = 1'b0;
		@(negedge fclk);
		m1_n   = 1'b1;
		mreq_n = 1'b1;
		rd_n   = 1'b1;
		repeat (2) @(negedge fclk);
		#(clk_period/4);
		check_value("dos", 32'(m_dos), 32'(dos));
	endtask

	task automatic set_modes(input logic off, input logic nmi, input logic r0);
		@(negedge fclk);
		pager_off = off;
		in_nmi    = nmi;
		ram0_0    = r0;
		repeat (3) @(negedge fclk); // window outputs are registered
	endtask

	initial
	begin
		logic [31:0] r;
		logic [1:0]  hi;
		{zpos, zneg, za, zd} = {1'b1, 1'b0, 16'h0000, 8'h00};
		{mreq_n, iorq_n, rd_n, wr_n, m1_n} = 5'b11111;
		{pager_off, in_nmi, ram0_0} = 3'b000;
		for (int w = 0; w < 4; w++)
			for (int b = 0; b < 2; b++)
				{m_page[w][b], m_ram[w][b], m_dos7[w][b]} = 10'd0;
		{m_rom_sel, m_dos, m_pent} = 8'd0;
		arst_n = 1'b0;
		repeat (rst_cycles) @(negedge fclk);
		arst_n = 1'b1;

		open_test("reset");
		for (int w = 0; w < 4; w++)
			read_check(w);
		check_value("dos", 32'd0, 32'(dos));
		check_value("zclk_stall", 32'd0, 32'(zclk_stall));
		close_test();

		open_test("atm_4mb");
		repeat (16)
		begin
			r = rand32();
			io_write({r[15:12], 1'b0, r[10:8], 8'hF7}, r[23:16]);
			read_check(int'(r[15:14]));
		end
		close_test();

		open_test("atm_1mb_7ffd");
		repeat (24)
		begin
			r = rand32();
			if (r[0])
				io_write(16'h7FFD, r[15:8]);
			else
				io_write({r[31:28], 1'b1, r[26:24], 8'hF7}, {1'b1, r[22:16]});
			for (int w = 0; w < 4; w++)
				read_check(w);
		end
		close_test();

		open_test("dos");
		for (int i = 0; i < 6; i++)
		begin
			r = rand32();
			io_write(16'h7FFD, {r[7:5], (i % 3 != 2), r[3:0]}); // rom_sel mostly set
			opcode_fetch({8'h3D, r[15:8]});
			for (int w = 0; w < 4; w++)
				read_check(w);
			hi = (r[17:16] == 2'b00) ? 2'b01 : r[17:16];
			opcode_fetch({hi, r[29:16]});
		end
		close_test();

		open_test("override");
		set_modes(1'b1, 1'b1, 1'b1);
		for (int w = 0; w < 4; w++)
			read_check(w);
		set_modes(1'b0, 1'b1, 1'b1); // nmi ahead of ram0
		read_check(0);
		set_modes(1'b0, 1'b0, 1'b1);
		read_check(0);
		read_check(1);
		set_modes(1'b0, 1'b0, 1'b0);
		read_check(0);
		close_test();

		$display("total: %0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

endmodule : tb_mem_pager

// File: all.f
rtl/pager_pkg.sv
rtl/zbus_if.sv
rtl/port_decoder.sv
rtl/window_pager.sv
rtl/dos_tracker.sv
rtl/mem_addr_mux.sv
rtl/mem_pager_top.sv
verif/mem_pager_checker.sv
verif/tb_mem_pager.sv

// File: run.sh
#!/usr/bin/env bash
# build the pager testbench with Verilator, run it, pass only if the pass line shows up
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module tb_mem_pager -f all.f --Mdir obj_dir
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

out="$(./obj_dir/Vtb_mem_pager)"
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -qx "STATUS: PASS"; then
	exit 0
fi
exit 1
